//--- logic/window_pkg.sv
package window_pkg;

  // **************************************************
  // Data widths
  // **************************************************

  localparam int DWIDTH = 16;                  // Pixel width.
  localparam int LWIDTH = 8;                   // Width of the size fields.

  typedef logic signed [DWIDTH-1:0] pixel_t;

  // Run-time frame geometry that stays stable during a frame.
  typedef struct packed {
    logic [LWIDTH-1:0] img_size;               // Square image edge.
    logic [LWIDTH-1:0] fil_size;               // Filter edge.
    logic [LWIDTH-1:0] pad_size;               // Zero border on each side.
  } geometry_t;

  // Scan position over the padded frame.
  typedef struct packed {
    logic [LWIDTH-1:0] col;                    // Padded column.
    logic [LWIDTH-1:0] row;                    // Scan row since the request.
    logic [3:0]        line;                   // Ring slot being written.
  } scan_pos_t;

  typedef enum logic [1:0] {
    st_wait,
    st_charge,
    st_active
  } frame_state_t;

endpackage

//--- logic/frame_fsm.sv
`timescale 1ns/100ps

module frame_fsm (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     buf_req,
  input  logic                     charge_end,
  input  logic                     active_end,
  output window_pkg::frame_state_t state,
  output logic                     buf_ack
);

  window_pkg::frame_state_t state_next;

  // **************************************************
  // Next state
  // **************************************************

  always_comb begin
    state_next = state;
    case (state)
      window_pkg::st_wait: begin
        if (buf_req) begin
          state_next = window_pkg::st_charge;  // Start filling the ring.
        end
      end
      window_pkg::st_charge: begin
        if (charge_end) begin
          state_next = window_pkg::st_active;
        end
      end
      window_pkg::st_active: begin
        if (active_end) begin
          state_next = window_pkg::st_wait;    // Last padded row done.
        end
      end
      default: begin
        state_next = window_pkg::st_wait;
      end
    endcase
  end

  // **************************************************
  // State register
  // **************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= window_pkg::st_wait;
    end else begin
      state <= state_next;
    end
  end

  // Idle means ready for a new frame.
  assign buf_ack = (state == window_pkg::st_wait);

endmodule

//--- logic/scan_counter.sv
`timescale 1ns/100ps

module scan_counter #(
  parameter int MAXFIL = 5,
  parameter int MAXIMG = 32
) (
  input  logic                             clk,
  input  logic                             xrst,
  input  logic                             buf_req,
  input  window_pkg::frame_state_t         state,
  input  window_pkg::geometry_t            geom,
  output window_pkg::scan_pos_t            pos,
  output logic                             col_wrap,
  output logic                             charge_end,
  output logic                             active_end,
  output logic                             in_col,
  output logic                             buf_ready
);

  localparam int MAXPAD = (MAXFIL - 1) / 2;
  localparam int RING   = MAXFIL + 1;
  localparam int CWIDTH = $clog2(MAXIMG + 2 * MAXPAD + 1);

  logic [CWIDTH-1:0]             col_cnt;
  logic [CWIDTH-1:0]             row_cnt;
  logic [3:0]                    line_cnt;
  logic [window_pkg::LWIDTH-1:0] pad_width;     // Padded row length.
  logic [window_pkg::LWIDTH-1:0] col_next;
  logic [window_pkg::LWIDTH-1:0] row_next;
  logic                          running;
  logic                          ready_body;
  logic                          ready_lead;

  // **************************************************
  // Counters
  // **************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_cnt <= '0;
    end else if (!running) begin
      col_cnt  <= '0;
      row_cnt  <= '0;
      line_cnt <= '0;
    end else if (col_wrap) begin
      col_cnt  <= '0;
      row_cnt  <= row_cnt + 1'b1;
      line_cnt <= (line_cnt == 4'(RING - 1)) ? 4'd0 : line_cnt + 1'b1;  // Ring step.
    end else begin
      col_cnt <= col_cnt + 1'b1;
    end
  end

  assign pos.col  = {{(window_pkg::LWIDTH - CWIDTH){1'b0}}, col_cnt};
  assign pos.row  = {{(window_pkg::LWIDTH - CWIDTH){1'b0}}, row_cnt};
  assign pos.line = line_cnt;

  // **************************************************
  // Position conditions
  // **************************************************

  assign running   = (state != window_pkg::st_wait);
  assign pad_width = geom.img_size + (geom.pad_size << 1);
  assign col_next  = pos.col + 1'b1;
  assign row_next  = pos.row + 1'b1;

  assign col_wrap   = running && (pos.col == pad_width - 1'b1);
  assign charge_end = col_wrap && (pos.row == geom.fil_size - geom.pad_size - 1'b1);
  assign active_end = col_wrap && (pos.row == geom.img_size + geom.pad_size);
  assign in_col     = (pos.col >= geom.fil_size - 1'b1);   // Window fully inside row.

  // The pixel is captured one cycle ahead of its padded column.
  assign ready_body = running && (pos.row < geom.img_size)
                   && (col_next >= geom.pad_size)
                   && (col_next < geom.img_size + geom.pad_size);

  // Without padding the first column is fetched in the cycle before the row.
  assign ready_lead = (geom.pad_size == '0)
                   && (running ? (col_wrap && (row_next < geom.img_size)) : buf_req);

  assign buf_ready = ready_body || ready_lead;

endmodule

//--- logic/line_mem.sv
`timescale 1ns/100ps

module line_mem #(
  parameter int DEPTH = 36
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  window_pkg::pixel_t       wdata,
  output window_pkg::pixel_t       rdata
);

  window_pkg::pixel_t mem [DEPTH];              // One padded row.

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read is combinational from the write address.
  assign rdata = mem[addr];

endmodule

//--- logic/window_shift.sv
`timescale 1ns/100ps

module window_shift #(
  parameter int MAXFIL = 5
) (
  input  logic                                          clk,
  input  logic                                          xrst,
  input  window_pkg::frame_state_t                      state,
  input  window_pkg::geometry_t                         geom,
  input  window_pkg::scan_pos_t                         pos,
  input  logic                                          col_wrap,
  input  logic                                          in_col,
  input  logic                                          buf_ready,
  input  window_pkg::pixel_t                            buf_input,
  output logic [MAXFIL:0]                               mem_we,
  output window_pkg::pixel_t                            mem_wdata,
  input  window_pkg::pixel_t [MAXFIL:0]                 mem_rdata,
  output logic                                          buf_valid,
  output window_pkg::pixel_t [MAXFIL*MAXFIL-1:0]        buf_window
);

  localparam int RING = MAXFIL + 1;
  localparam int WIN  = MAXFIL * MAXFIL;

  window_pkg::pixel_t                in_q;        // Captured pixel or zero on pad columns.
  logic [3:0]                        select;      // Slot of the oldest window row.
  logic [MAXFIL-1:0][3:0]            slot;
  logic [MAXFIL-1:0]                 row_ok;
  window_pkg::pixel_t [MAXFIL-1:0]   row_data;    // Newest column per window row.
  logic [window_pkg::LWIDTH-1:0]     fil_q;
  window_pkg::pixel_t [WIN-1:0]      win_q;
  logic [1:0]                        valid_q;

  // **************************************************
  // Line memory write side
  // **************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_q <= '0;
    end else if (buf_ready) begin
      in_q <= buf_input;
    end else begin
      in_q <= '0;
    end
  end

  assign mem_wdata = in_q;

  for (genvar k = 0; k < RING; k++) begin : g_we
    assign mem_we[k] = (state != window_pkg::st_wait) && (pos.line == 4'(k));
  end

  // **************************************************
  // Row select ring
  // **************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      select <= '0;
    end else if (state == window_pkg::st_wait) begin
      select <= 4'(RING) - geom.fil_size[3:0];   // Row minus filter modulo the ring.
    end else if (col_wrap) begin
      select <= (select == 4'(RING - 1)) ? 4'd0 : select + 1'b1;
    end
  end

  for (genvar i = 0; i < MAXFIL; i++) begin : g_row
    localparam logic [3:0]                    OFS = i;
    localparam logic [window_pkg::LWIDTH-1:0] IDX = i;
    logic [3:0]                    slot_sum;
    logic [window_pkg::LWIDTH-1:0] row_sum;

    assign slot_sum  = select + OFS;
    assign slot[i]   = (slot_sum >= 4'(RING)) ? slot_sum - 4'(RING) : slot_sum;
    assign row_sum   = pos.row + IDX;
    // Zero above the image and below it.
    assign row_ok[i] = (row_sum >= geom.fil_size)
                    && (row_sum < geom.img_size + geom.fil_size);
  end

  // **************************************************
  // Window array
  // **************************************************

  always_ff @(posedge clk) begin
    if (!xrst) begin
      row_data <= '0;
      fil_q    <= '0;
      win_q    <= '0;
      valid_q  <= '0;
    end else begin
      fil_q   <= geom.fil_size;                   // Travels with row_data.
      valid_q <= {valid_q[0], (state == window_pkg::st_active) && in_col};
      for (int i = 0; i < MAXFIL; i++) begin
        row_data[i] <= row_ok[i] ? mem_rdata[slot[i]] : '0;
        for (int j = 0; j < MAXFIL - 1; j++) begin
          if (int'(fil_q) == j + 1) begin
            win_q[i*MAXFIL+j] <= row_data[i];     // Newest column enters here.
          end else begin
            win_q[i*MAXFIL+j] <= win_q[i*MAXFIL+j+1];
          end
        end
        win_q[i*MAXFIL+MAXFIL-1] <= row_data[i];
      end
    end
  end

  assign buf_valid  = valid_q[1];
  assign buf_window = win_q;

endmodule

//--- logic/linebuf_pad_top.sv
`timescale 1ns/100ps

module linebuf_pad_top #(
  parameter int MAXFIL = 5,
  parameter int MAXIMG = 32
) (
  input  logic                                   clk,
  input  logic                                   xrst,
  input  logic                                   buf_req,
  input  window_pkg::geometry_t                  geom,
  input  window_pkg::pixel_t                     buf_input,
  output logic                                   buf_ack,
  output logic                                   buf_ready,
  output logic                                   buf_valid,
  output window_pkg::pixel_t [MAXFIL*MAXFIL-1:0] buf_window
);

  localparam int MAXPAD = (MAXFIL - 1) / 2;
  localparam int RING   = MAXFIL + 1;
  localparam int DEPTH  = MAXIMG + 2 * MAXPAD;    // Widest padded row.
  localparam int AWIDTH = $clog2(DEPTH);

  window_pkg::frame_state_t          state;
  window_pkg::scan_pos_t             pos;
  logic                              col_wrap;
  logic                              charge_end;
  logic                              active_end;
  logic                              in_col;
  logic [MAXFIL:0]                   mem_we;
  window_pkg::pixel_t                mem_wdata;
  window_pkg::pixel_t [MAXFIL:0]     mem_rdata;

  frame_fsm u_frame_fsm (
    .clk        (clk),
    .xrst       (xrst),
    .buf_req    (buf_req),
    .charge_end (charge_end),
    .active_end (active_end),
    .state      (state),
    .buf_ack    (buf_ack)
  );

  scan_counter #(
    .MAXFIL (MAXFIL),
    .MAXIMG (MAXIMG)
  ) u_scan_counter (
    .clk        (clk),
    .xrst       (xrst),
    .buf_req    (buf_req),
    .state      (state),
    .geom       (geom),
    .pos        (pos),
    .col_wrap   (col_wrap),
    .charge_end (charge_end),
    .active_end (active_end),
    .in_col     (in_col),
    .buf_ready  (buf_ready)
  );

  window_shift #(
    .MAXFIL (MAXFIL)
  ) u_window_shift (
    .clk        (clk),
    .xrst       (xrst),
    .state      (state),
    .geom       (geom),
    .pos        (pos),
    .col_wrap   (col_wrap),
    .in_col     (in_col),
    .buf_ready  (buf_ready),
    .buf_input  (buf_input),
    .mem_we     (mem_we),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .buf_valid  (buf_valid),
    .buf_window (buf_window)
  );

  // One line memory per ring slot.
  for (genvar k = 0; k < RING; k++) begin : g_line
    line_mem #(
      .DEPTH (DEPTH)
    ) u_line_mem (
      .clk   (clk),
      .we    (mem_we[k]),
      .addr  (pos.col[AWIDTH-1:0]),
      .wdata (mem_wdata),
      .rdata (mem_rdata[k])
    );
  end

endmodule

//--- testbench/tb_linebuf_pad.sv
`timescale 1ns/100ps

module tb_linebuf_pad;

  localparam int MAXFIL  = 5;
  localparam int MAXIMG  = 32;
  // Twice the summed (img+2*pad+1)^2 of all tests plus slack.
  localparam int TIMEOUT = 2 * (9 * 9 + 11 * 11 + 17 * 17 + 12 * 12 + 11 * 11) + 100;

  logic                                   clk;
  logic                                   xrst;
  logic                                   buf_req;
  window_pkg::geometry_t                  geom;
  window_pkg::pixel_t                     buf_input;
  logic                                   buf_ack;
  logic                                   buf_ready;
  logic                                   buf_valid;
  window_pkg::pixel_t [MAXFIL*MAXFIL-1:0] buf_window;

  window_pkg::pixel_t image [MAXIMG*MAXIMG];  // Raster order source image.
  logic [31:0]        lfsr;
  string              test_name;
  int                 cur_img;
  int                 cur_fil;
  int                 cur_pad;
  int                 out_w;                  // Windows per output row.
  int                 win_total;              // Written by the collector only.
  int                 win_base;
  int                 cycle_cnt;

  linebuf_pad_top #(
    .MAXFIL (MAXFIL),
    .MAXIMG (MAXIMG)
  ) u_dut (
    .clk        (clk),
    .xrst       (xrst),
    .buf_req    (buf_req),
    .geom       (geom),
    .buf_input  (buf_input),
    .buf_ack    (buf_ack),
    .buf_ready  (buf_ready),
    .buf_valid  (buf_valid),
    .buf_window (buf_window)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // **************************************************
  // Helpers
  // **************************************************

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string label, input int expected, input int actual);
    if (expected != actual) begin
      report_failure($sformatf("ERROR %s: expected %0d, actual %0d", label, expected, actual));
    end
  endtask

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_pixel(output window_pkg::pixel_t px);
    window_pkg::pixel_t value;
    for (int b = 0; b < window_pkg::DWIDTH; b++) begin
      lfsr     = lfsr_next(lfsr);
      value[b] = lfsr[0];                     // One step per bit.
    end
    px = value;
  endtask

  task automatic load_ramp(input int img);
    for (int k = 0; k < img * img; k++) begin
      image[k] = 16'((k / img) * 16 + (k % img) - 40);  // Crosses zero.
    end
  endtask

  task automatic load_random(input int img);
    for (int k = 0; k < img * img; k++) begin
      random_pixel(image[k]);
    end
  endtask

  // Window k holds image[r+i-pad][c+j-pad] or zero off the image.
  task automatic check_window(input int k);
    int y;
    int x;
    int exp_px;
    for (int i = 0; i < cur_fil; i++) begin
      for (int j = 0; j < cur_fil; j++) begin
        y      = k / out_w + i - cur_pad;
        x      = k % out_w + j - cur_pad;
        exp_px = (y >= 0 && y < cur_img && x >= 0 && x < cur_img) ?
                 int'(image[y * cur_img + x]) : 0;
        check_equal($sformatf("%s window %0d element [%0d][%0d]", test_name, k, i, j),
                    exp_px, int'(buf_window[i * MAXFIL + j]));
      end
    end
  endtask

  task automatic feed_pixel(inout int fed);
    if (!buf_ready) begin
      buf_input = '0;
    end else if (fed >= cur_img * cur_img) begin
      report_failure($sformatf("%s: buf_ready was high more often than the image has pixels",
                               test_name));
    end else begin
      buf_input = image[fed];
      fed++;
    end
  endtask

  // **************************************************
  // Frame driver and window collector
  // **************************************************

  task automatic run_frame(input string name, input int img, input int fil, input int pad);
    int fed;
    fed       = 0;
    test_name = name;
    cur_img   = img;
    cur_fil   = fil;
    cur_pad   = pad;
    out_w     = img + 2 * pad - fil + 1;
    win_base  = win_total;
    @(negedge clk);
    check_equal({name, " buf_ack before request"}, 1, int'(buf_ack));
    geom.img_size = 8'(img);
    geom.fil_size = 8'(fil);
    geom.pad_size = 8'(pad);
    buf_req       = 1'b1;
    #1;                                       // Ready may follow buf_req at once.
    feed_pixel(fed);
    @(negedge clk);
    buf_req = 1'b0;
    while (!buf_ack) begin
      feed_pixel(fed);
      @(negedge clk);
    end
    repeat (4) @(negedge clk);                // Drain the valid pipeline.
    check_equal({name, " pixels taken"}, img * img, fed);
    check_equal({name, " window count"}, out_w * out_w, win_total - win_base);
  endtask

  always @(negedge clk) begin
    if (xrst && buf_valid) begin
      if (win_total - win_base >= out_w * out_w) begin
        report_failure($sformatf("%s produced more windows than expected", test_name));
      end else begin
        check_window(win_total - win_base);
        win_total++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      report_failure("Timeout: a frame did not return buf_ack in time");
    end
  end

  // **************************************************
  // Tests
  // **************************************************

  task automatic reset_values();
    check_equal("reset buf_ack", 1, int'(buf_ack));
    check_equal("reset buf_valid", 0, int'(buf_valid));
    check_equal("reset buf_ready", 0, int'(buf_ready));
    check_equal("reset window zero", 1, int'(buf_window == '0));
  endtask

  task automatic ramp_pad0();
    load_ramp(8);
    run_frame("ramp_f3_p0", 8, 3, 0);         // 36 windows.
  endtask

  task automatic random_pad1();
    load_random(8);
    run_frame("random_f3_p1", 8, 3, 1);       // 64 windows.
  endtask

  task automatic full_window();
    load_random(12);
    run_frame("random_f5_p2", 12, 5, 2);      // Full ring and 144 windows.
  endtask

  task automatic back_to_back();
    load_random(7);
    run_frame("b2b_first_f5_p2", 7, 5, 2);
    load_random(10);
    run_frame("b2b_second_f3_p0", 10, 3, 0);
  endtask

  initial begin
    xrst      = 1'b0;
    buf_req   = 1'b0;
    geom      = '0;
    buf_input = '0;
    lfsr      = 32'h978a75c3;
    win_total = 0;
    win_base  = 0;
    cycle_cnt = 0;
    out_w     = 0;
    repeat (4) @(negedge clk);
    xrst = 1'b1;
    reset_values();
    ramp_pad0();
    random_pad1();
    full_window();
    back_to_back();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- src.f
logic/window_pkg.sv
logic/frame_fsm.sv
logic/scan_counter.sv
logic/line_mem.sv
logic/window_shift.sv
logic/linebuf_pad_top.sv
testbench/tb_linebuf_pad.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f src.f --top-module tb_linebuf_pad || exit 1
out=$(./obj_dir/Vtb_linebuf_pad 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
